// File: list.f
design/core_pkg.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/forward_stall.sv
design/pipeline_top.sv
tests/tb_clock.sv
tests/pipeline_tb.sv

// File: tests/pipeline_tb.sv
/*
 Testbench for the pipeline: Wishbone instruction memory with fixed or
 random wait states, an instruction-set reference model and directed tests
*/
`default_nettype none

module pipeline_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // 40 retires x 6 tests x (4 wait + 1 idle) cycles, doubled for
    // flushed fetches and resets, plus margin
    localparam int CYCLE_LIMIT = 3000;

    localparam int F3_ADD = 3'b000;
    localparam int F3_SLT = 3'b010;
    localparam int F3_XOR = 3'b100;
    localparam int F3_OR  = 3'b110;
    localparam int F3_AND = 3'b111;
    localparam int F7_STD = 7'b0000000;
    localparam int F7_ALT = 7'b0100000;

    logic     clk;
    logic     rst_n;
    logic     imem_cyc;
    logic     imem_stb;
    addr_t    imem_adr;
    instr_t   imem_dat = '0;
    logic     imem_ack = 1'b0;
    logic     retire_valid;
    addr_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_we;
    word_t    retire_data;

    // Memory model state
    instr_t   mem [256];
    int       prog_len;
    int       ack_delay = 0;
    bit       random_delay = 1'b0;
    integer   seed = 32'h460c;
    int       wait_left;
    bit       in_cycle = 1'b0;
    bit       ack_seen [4096];
    addr_t    ack_addr [4096];

    // Expected retire sequence
    addr_t    exp_pc [$];
    reg_idx_t exp_rd [$];
    logic     exp_we [$];
    word_t    exp_data [$];

    int       cycle_count = 0;
    int       errors = 0;
    int       retired_total = 0;
    int       tests_run = 0;

    tb_clock i_clock (
        .clk_o (clk)
    );

    pipeline_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_cyc_o     (imem_cyc),
        .imem_stb_o     (imem_stb),
        .imem_adr_o     (imem_adr),
        .imem_dat_i     (imem_dat),
        .imem_ack_i     (imem_ack),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_we_o    (retire_we),
        .retire_data_o  (retire_data)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // Wishbone slave, one ack per cycle after the chosen wait
    always @(negedge clk) begin
        if (imem_ack) begin
            imem_ack = 1'b0;
            in_cycle = 1'b0;
        end else if (imem_cyc && imem_stb) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                wait_left = random_delay ? {$random(seed)} % 4 : ack_delay;
            end
            if (wait_left == 0) begin
                imem_ack = 1'b1;
                imem_dat = mem[imem_adr[9:2]];
                ack_seen[cycle_count] = 1'b1;
                ack_addr[cycle_count] = imem_adr;
            end else begin
                wait_left--;
            end
        end else begin
            in_cycle = 1'b0;
        end
    end

    function automatic instr_t rtype(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic instr_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic instr_t lui(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], OPC_LUI};
    endfunction

    function automatic instr_t branch(input int f3, input int rs1, input int rs2,
                                      input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3[2:0], o[4:1], o[11], OPC_BRANCH};
    endfunction

    function automatic instr_t jal(input int rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd[4:0], OPC_JAL};
    endfunction

    // Unused words hold an unsupported opcode tagged with their index
    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[24:0], 7'b1111111};
        end
        prog_len = 0;
    endtask

    task automatic emit(input instr_t ins);
        mem[prog_len] = ins;
        prog_len++;
    endtask

    // Instruction-set model of the supported subset
    task automatic predict_retires(input int count);
        word_t    regs [32];
        addr_t    pc;
        addr_t    next_pc;
        instr_t   ins;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    res;
        logic     we;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_we.delete();
        exp_data.delete();
        pc = RESET_PC;
        for (int n = 0; n < count; n++) begin
            ins     = mem[pc[9:2]];
            opc     = ins[6:0];
            f3      = ins[14:12];
            f7      = ins[31:25];
            rd      = ins[11:7];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            we      = 1'b0;
            res     = '0;
            next_pc = pc + 32'd4;
            case (opc)
                OPC_OP: begin
                    we = 1'b1;
                    if (f7 == F7_STD && f3 == F3_ADD) begin
                        res = a + b;
                    end else if (f7 == F7_ALT && f3 == F3_ADD) begin
                        res = a - b;
                    end else if (f7 == F7_STD && f3 == F3_AND) begin
                        res = a & b;
                    end else if (f7 == F7_STD && f3 == F3_OR) begin
                        res = a | b;
                    end else if (f7 == F7_STD && f3 == F3_XOR) begin
                        res = a ^ b;
                    end else if (f7 == F7_STD && f3 == F3_SLT) begin
                        res = ($signed(a) < $signed(b)) ? 1 : 0;
                    end else begin
                        we = 1'b0;
                    end
                end
                OPC_OP_IMM: begin
                    we  = (f3 == 3'b000);
                    res = a + {{20{ins[31]}}, ins[31:20]};
                end
                OPC_LUI: begin
                    we  = 1'b1;
                    res = {ins[31:12], 12'h000};
                end
                OPC_BRANCH: begin
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    we      = 1'b1;
                    res     = pc + 32'd4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: begin
                end
            endcase
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_we.push_back(we);
            exp_data.push_back(res);
            if (we && rd != 0) begin
                regs[rd] = res;
            end
            pc = next_pc;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic report_mismatch(input string name, input string what, input int idx,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("mismatch in %s: retire %0d %s expected %h actual %h",
                 name, idx, what, expected, actual);
        errors++;
    endtask

    // Resets the DUT and compares each retire with the reference model
    task automatic run_program(input string name, input int count, input bit rand_wait,
                               input int fixed_wait, input bit check_timing);
        int got;
        int errors_before;
        errors_before = errors;
        predict_retires(count);
        random_delay = rand_wait;
        ack_delay    = fixed_wait;
        reset_dut();
        got = 0;
        while (got < count) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                if (retire_pc !== exp_pc[got]) begin
                    report_mismatch(name, "pc", got, exp_pc[got], retire_pc);
                end
                if (retire_we !== exp_we[got]) begin
                    report_mismatch(name, "we", got, exp_we[got], retire_we);
                end
                if (exp_we[got] && retire_rd !== exp_rd[got]) begin
                    report_mismatch(name, "rd", got, exp_rd[got], retire_rd);
                end
                if (exp_we[got] && retire_data !== exp_data[got]) begin
                    report_mismatch(name, "data", got, exp_data[got], retire_data);
                end
                // Zero wait: ack edge, then IF/ID, ID/EX and EX/WB
                if (check_timing) begin
                    if (!ack_seen[cycle_count - 3] ||
                            ack_addr[cycle_count - 3] !== retire_pc) begin
                        $display("error in %s: retire %0d at pc %h did not follow its ack by 3 cycles",
                                 name, got, retire_pc);
                        errors++;
                    end
                end
                got++;
            end
        end
        retired_total += got;
        tests_run++;
        $display("test %s: %0d retires checked, %0d errors", name, got, errors - errors_before);
    endtask

    task automatic alu_mix_program();
        fill_memory();
        emit(addi(1, 0, 25));
        emit(addi(2, 0, -7));
        emit(lui(3, 20'h12345));
        emit(addi(4, 0, 2047));
        emit(addi(5, 0, -2048));
        emit(rtype(F7_STD, F3_ADD, 6, 1, 2));
        emit(rtype(F7_ALT, F3_ADD, 7, 1, 2));
        emit(rtype(F7_STD, F3_AND, 8, 3, 4));
        emit(rtype(F7_STD, F3_OR, 9, 3, 2));
        emit(rtype(F7_STD, F3_XOR, 10, 4, 5));
        emit(rtype(F7_STD, F3_SLT, 11, 2, 1));
        emit(rtype(F7_STD, F3_SLT, 12, 1, 2));
        emit(addi(13, 3, 12'h123));
        emit(lui(14, 20'hfffff));
        emit(jal(0, 0));
    endtask

    // Distance one and two dependencies on every source
    task automatic dependency_program();
        fill_memory();
        emit(addi(1, 0, 5));
        emit(addi(2, 1, 3));
        emit(rtype(F7_STD, F3_ADD, 3, 2, 1));
        emit(rtype(F7_ALT, F3_ADD, 4, 3, 2));
        emit(rtype(F7_STD, F3_XOR, 5, 4, 4));
        emit(rtype(F7_STD, F3_OR, 6, 5, 3));
        emit(rtype(F7_STD, F3_AND, 7, 6, 4));
        emit(rtype(F7_STD, F3_SLT, 8, 7, 6));
        emit(addi(8, 8, 100));
        emit(lui(9, 20'h80000));
        emit(rtype(F7_STD, F3_ADD, 10, 9, 8));
        emit(rtype(F7_STD, F3_SLT, 11, 10, 8));
        emit(rtype(F7_ALT, F3_ADD, 1, 1, 11));
        emit(rtype(F7_STD, F3_ADD, 12, 1, 1));
        emit(jal(0, 0));
    endtask

    task automatic branch_program();
        fill_memory();
        emit(addi(1, 0, 3));
        emit(addi(2, 0, 3));
        emit(branch(3'b000, 1, 2, 12));
        emit(addi(3, 0, 111));
        emit(addi(4, 0, 222));
        emit(branch(3'b001, 1, 2, 12));
        emit(addi(5, 0, 1));
        emit(branch(3'b001, 5, 2, 12));
        emit(addi(6, 0, 333));
        emit(addi(7, 0, 444));
        emit(branch(3'b000, 5, 1, 8));
        emit(jal(8, 12));
        emit(addi(9, 0, 555));
        emit(addi(10, 0, 666));
        emit(addi(11, 8, 1));
        // Backward loop runs three times
        emit(addi(1, 1, -1));
        emit(branch(3'b001, 1, 0, -4));
        emit(jal(0, 0));
    endtask

    task automatic x0_program();
        fill_memory();
        emit(addi(1, 0, 9));
        emit(addi(0, 1, 5));
        emit(rtype(F7_STD, F3_ADD, 2, 0, 1));
        emit(rtype(F7_STD, F3_ADD, 3, 0, 0));
        emit(lui(0, 20'habcde));
        emit(rtype(F7_STD, F3_OR, 4, 0, 1));
        // LW, MUL, SLLI and BLT are outside the subset
        emit(32'h0000_2083);
        emit(rtype(7'b0000001, F3_ADD, 5, 1, 1));
        emit({12'h001, 5'd1, 3'b001, 5'd6, OPC_OP_IMM});
        emit(branch(3'b100, 0, 1, 8));
        emit(rtype(F7_STD, F3_ADD, 7, 5, 6));
        emit(32'h0000_0000);
        emit(jal(0, 0));
    endtask

    task automatic reset_state_test();
        int errors_before;
        errors_before = errors;
        alu_mix_program();
        random_delay = 1'b0;
        ack_delay    = 0;
        reset_dut();
        if (imem_cyc !== 1'b0 || imem_stb !== 1'b0) begin
            $display("error in reset_state: Wishbone cycle active during reset");
            errors++;
        end
        if (retire_valid !== 1'b0) begin
            $display("error in reset_state: retire valid high during reset");
            errors++;
        end
        @(negedge clk);
        if (imem_cyc !== 1'b1) begin
            $display("error in reset_state: no Wishbone cycle on the first cycle after reset");
            errors++;
        end
        if (imem_adr !== RESET_PC) begin
            $display("mismatch in reset_state: first address expected %h actual %h",
                     RESET_PC, imem_adr);
            errors++;
        end
        tests_run++;
        $display("test reset_state: %0d errors", errors - errors_before);
    endtask

    initial begin
        rst_n = 1'b0;
        reset_state_test();
        alu_mix_program();
        run_program("independent_alu", 17, 1'b0, 0, 1'b1);
        dependency_program();
        run_program("forwarding", 17, 1'b0, 0, 1'b1);
        branch_program();
        run_program("branch_jump", 17, 1'b0, 1, 1'b0);
        x0_program();
        run_program("x0_unsupported", 15, 1'b0, 2, 1'b0);
        dependency_program();
        run_program("random_wait", 17, 1'b1, 0, 1'b0);
        $display("%0d tests, %0d retires checked, %0d errors", tests_run, retired_total, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : pipeline_tb

`default_nettype wire

// File: tests/tb_clock.sv
/*
 Testbench clock source, 40 ns period
*/
`default_nettype none

module tb_clock (
    output logic clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Half of the 40 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o;
        end
    end

endmodule : tb_clock

`default_nettype wire

// File: design/pipeline_top.sv
/*
 Pipeline top: fetch, decode, execute and writeback stages with the
 register file and hazard unit, Wishbone fetch port and retire port
*/
`default_nettype none

module pipeline_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // Wishbone instruction port
    output logic     imem_cyc_o,
    output logic     imem_stb_o,
    output addr_t    imem_adr_o,
    input  instr_t   imem_dat_i,
    input  logic     imem_ack_i,

    // Retire port, driven by EX/WB
    output logic     retire_valid_o,
    output addr_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output logic     retire_we_o,
    output word_t    retire_data_o
);

    // IF/ID
    logic     id_valid;
    addr_t    id_pc;
    instr_t   id_instr;

    // Register file reads
    reg_idx_t rf_rs1;
    reg_idx_t rf_rs2;
    word_t    rf_rs1_data;
    word_t    rf_rs2_data;

    // ID/EX
    logic     ex_valid;
    addr_t    ex_pc;
    alu_op_e  ex_alu_op;
    word_t    ex_rs1_data;
    word_t    ex_rs2_data;
    word_t    ex_imm;
    reg_idx_t ex_rd;
    logic     ex_we;
    logic     ex_is_branch;
    logic     ex_branch_ne;
    logic     ex_is_jal;
    logic     ex_use_imm;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;

    // Hazard and redirect
    logic     fwd_rs1;
    logic     fwd_rs2;
    logic     flush_id;
    logic     flush_ex;
    logic     redirect;
    addr_t    redirect_pc;

    fetch_unit i_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_cyc_o    (imem_cyc_o),
        .imem_stb_o    (imem_stb_o),
        .imem_adr_o    (imem_adr_o),
        .imem_dat_i    (imem_dat_i),
        .imem_ack_i    (imem_ack_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .flush_id_i    (flush_id),
        .id_valid_o    (id_valid),
        .id_pc_o       (id_pc),
        .id_instr_o    (id_instr)
    );

    decode_unit i_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_valid_i     (id_valid),
        .id_pc_i        (id_pc),
        .id_instr_i     (id_instr),
        .rf_rs1_o       (rf_rs1),
        .rf_rs2_o       (rf_rs2),
        .rf_rs1_data_i  (rf_rs1_data),
        .rf_rs2_data_i  (rf_rs2_data),
        .flush_ex_i     (flush_ex),
        .ex_valid_o     (ex_valid),
        .ex_pc_o        (ex_pc),
        .ex_alu_op_o    (ex_alu_op),
        .ex_rs1_data_o  (ex_rs1_data),
        .ex_rs2_data_o  (ex_rs2_data),
        .ex_imm_o       (ex_imm),
        .ex_rd_o        (ex_rd),
        .ex_we_o        (ex_we),
        .ex_is_branch_o (ex_is_branch),
        .ex_branch_ne_o (ex_branch_ne),
        .ex_is_jal_o    (ex_is_jal),
        .ex_use_imm_o   (ex_use_imm),
        .ex_rs1_o       (ex_rs1),
        .ex_rs2_o       (ex_rs2)
    );

    // Written from EX/WB, which is the writeback stage
    register_file i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (rf_rs1),
        .rs2_i      (rf_rs2),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .we_i       (retire_we_o),
        .rd_i       (retire_rd_o),
        .wd_i       (retire_data_o)
    );

    execute_unit i_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid_i     (ex_valid),
        .ex_pc_i        (ex_pc),
        .ex_alu_op_i    (ex_alu_op),
        .ex_rs1_data_i  (ex_rs1_data),
        .ex_rs2_data_i  (ex_rs2_data),
        .ex_imm_i       (ex_imm),
        .ex_rd_i        (ex_rd),
        .ex_we_i        (ex_we),
        .ex_is_branch_i (ex_is_branch),
        .ex_branch_ne_i (ex_branch_ne),
        .ex_is_jal_i    (ex_is_jal),
        .ex_use_imm_i   (ex_use_imm),
        .fwd_rs1_i      (fwd_rs1),
        .fwd_rs2_i      (fwd_rs2),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .wb_valid_o     (retire_valid_o),
        .wb_rd_o        (retire_rd_o),
        .wb_we_o        (retire_we_o),
        .wb_data_o      (retire_data_o),
        .wb_pc_o        (retire_pc_o)
    );

    forward_stall i_forward_stall (
        .ex_rs1_i   (ex_rs1),
        .ex_rs2_i   (ex_rs2),
        .wb_valid_i (retire_valid_o),
        .wb_we_i    (retire_we_o),
        .wb_rd_i    (retire_rd_o),
        .redirect_i (redirect),
        .fwd_rs1_o  (fwd_rs1),
        .fwd_rs2_o  (fwd_rs2),
        .flush_id_o (flush_id),
        .flush_ex_o (flush_ex)
    );

endmodule : pipeline_top

`default_nettype wire

// File: design/forward_stall.sv
/*
 Hazard unit: forward selects for the execute operands and the
 flushes of the two younger stages on a redirect
*/
`default_nettype none

module forward_stall import core_pkg::*; (
    input  reg_idx_t ex_rs1_i,
    input  reg_idx_t ex_rs2_i,

    input  logic     wb_valid_i,
    input  logic     wb_we_i,
    input  reg_idx_t wb_rd_i,

    input  logic     redirect_i,

    output logic     fwd_rs1_o,
    output logic     fwd_rs2_o,
    output logic     flush_id_o,
    output logic     flush_ex_o
);

    logic wb_writes;

    // x0 never forwards
    assign wb_writes = wb_valid_i && wb_we_i && (wb_rd_i != '0);

    assign fwd_rs1_o = wb_writes && (wb_rd_i == ex_rs1_i);
    assign fwd_rs2_o = wb_writes && (wb_rd_i == ex_rs2_i);

    // Taken branch or JAL squashes IF/ID and ID/EX
    assign flush_id_o = redirect_i;
    assign flush_ex_o = redirect_i;

endmodule : forward_stall

`default_nettype wire

// File: design/execute_unit.sv
/*
 Execute stage: operand forwarding, ALU, branch and JAL resolution,
 and the EX/WB register that also forms the retire port
*/
`default_nettype none

module execute_unit import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // From ID/EX
    input  logic     ex_valid_i,
    input  addr_t    ex_pc_i,
    input  alu_op_e  ex_alu_op_i,
    input  word_t    ex_rs1_data_i,
    input  word_t    ex_rs2_data_i,
    input  word_t    ex_imm_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_we_i,
    input  logic     ex_is_branch_i,
    input  logic     ex_branch_ne_i,
    input  logic     ex_is_jal_i,
    input  logic     ex_use_imm_i,

    // Forward selects
    input  logic     fwd_rs1_i,
    input  logic     fwd_rs2_i,

    output logic     redirect_o,
    output addr_t    redirect_pc_o,

    // EX/WB register
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output logic     wb_we_o,
    output word_t    wb_data_o,
    output addr_t    wb_pc_o
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_result;
    addr_t pc_plus4;
    logic  cond_true;

    // Distance-one operands come from our own EX/WB register
    assign op_a     = fwd_rs1_i ? wb_data_o : ex_rs1_data_i;
    assign op_b_reg = fwd_rs2_i ? wb_data_o : ex_rs2_data_i;
    assign op_b     = ex_use_imm_i ? ex_imm_i : op_b_reg;
    assign pc_plus4 = ex_pc_i + 32'd4;

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_b;
        endcase
    end

    // BEQ on equal, BNE on not equal
    assign cond_true     = (op_a == op_b_reg) != ex_branch_ne_i;
    assign redirect_o    = ex_valid_i && ((ex_is_branch_i && cond_true) || ex_is_jal_i);
    assign redirect_pc_o = ex_pc_i + ex_imm_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i;
            wb_we_o    <= ex_valid_i && ex_we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_rd_i;
        wb_pc_o   <= ex_pc_i;
        wb_data_o <= ex_is_jal_i ? pc_plus4 : alu_result;
    end

endmodule : execute_unit

`default_nettype wire

// File: design/decode_unit.sv
/*
 Instruction decode: register fields, immediates, ALU operation and
 control bits, registered into the ID/EX pipeline register
*/
`default_nettype none

module decode_unit import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    // From IF/ID
    input  logic     id_valid_i,
    input  addr_t    id_pc_i,
    input  instr_t   id_instr_i,

    // Register file read ports
    output reg_idx_t rf_rs1_o,
    output reg_idx_t rf_rs2_o,
    input  word_t    rf_rs1_data_i,
    input  word_t    rf_rs2_data_i,

    input  logic     flush_ex_i,

    // ID/EX register
    output logic     ex_valid_o,
    output addr_t    ex_pc_o,
    output alu_op_e  ex_alu_op_o,
    output word_t    ex_rs1_data_o,
    output word_t    ex_rs2_data_o,
    output word_t    ex_imm_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_we_o,
    output logic     ex_is_branch_o,
    output logic     ex_branch_ne_o,
    output logic     ex_is_jal_o,
    output logic     ex_use_imm_o,
    output reg_idx_t ex_rs1_o,
    output reg_idx_t ex_rs2_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    alu_op_e    alu_op;
    word_t      imm;
    logic       we;
    logic       is_branch;
    logic       is_jal;
    logic       use_imm;

    assign opcode   = id_instr_i[6:0];
    assign funct3   = id_instr_i[14:12];
    assign funct7   = id_instr_i[31:25];
    assign rf_rs1_o = id_instr_i[19:15];
    assign rf_rs2_o = id_instr_i[24:20];

    assign imm_i = {{20{id_instr_i[31]}}, id_instr_i[31:20]};
    assign imm_u = {id_instr_i[31:12], 12'b0};
    assign imm_b = {{20{id_instr_i[31]}}, id_instr_i[7], id_instr_i[30:25],
                    id_instr_i[11:8], 1'b0};
    assign imm_j = {{12{id_instr_i[31]}}, id_instr_i[19:12], id_instr_i[20],
                    id_instr_i[30:21], 1'b0};

    // Anything outside the subset falls through with no register write
    always_comb begin
        alu_op    = ALU_ADD;
        imm       = imm_i;
        we        = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        use_imm   = 1'b0;
        case (opcode)
            OPC_OP: begin
                we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_010: alu_op = ALU_SLT;
                    default:         we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                we      = (funct3 == 3'b000);
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                imm     = imm_u;
                we      = 1'b1;
                use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                // BEQ and BNE differ in funct3[0]
                imm       = imm_b;
                is_branch = (funct3[2:1] == 2'b00);
            end
            OPC_JAL: begin
                imm    = imm_j;
                we     = 1'b1;
                is_jal = 1'b1;
            end
            default: begin
                we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_ex_i) begin
            ex_valid_o     <= 1'b0;
            ex_we_o        <= 1'b0;
            ex_is_branch_o <= 1'b0;
            ex_is_jal_o    <= 1'b0;
        end else begin
            ex_valid_o     <= id_valid_i;
            ex_we_o        <= id_valid_i && we;
            ex_is_branch_o <= id_valid_i && is_branch;
            ex_is_jal_o    <= id_valid_i && is_jal;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o        <= id_pc_i;
        ex_alu_op_o    <= alu_op;
        ex_rs1_data_o  <= rf_rs1_data_i;
        ex_rs2_data_o  <= rf_rs2_data_i;
        ex_imm_o       <= imm;
        ex_rd_o        <= id_instr_i[11:7];
        ex_branch_ne_o <= funct3[0];
        ex_use_imm_o   <= use_imm;
        ex_rs1_o       <= rf_rs1_o;
        ex_rs2_o       <= rf_rs2_o;
    end

endmodule : decode_unit

`default_nettype wire

// File: design/fetch_unit.sv
/*
 Instruction fetch: PC, one Wishbone classic read at a time,
 redirect handling and the IF/ID pipeline register
*/
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,

    // Wishbone classic read-only master
    output logic   imem_cyc_o,
    output logic   imem_stb_o,
    output addr_t  imem_adr_o,
    input  instr_t imem_dat_i,
    input  logic   imem_ack_i,

    // Redirect from execute and flush from hazard logic
    input  logic   redirect_i,
    input  addr_t  redirect_pc_i,
    input  logic   flush_id_i,

    // IF/ID register
    output logic   id_valid_o,
    output addr_t  id_pc_o,
    output instr_t id_instr_o
);

    fetch_state_e state_q;
    addr_t        pc_q;
    addr_t        adr_q;
    logic         fetch_done;

    // Word usable only when the cycle was not overtaken by a redirect
    assign fetch_done = (state_q == FETCH_WAIT) && imem_ack_i;

    assign imem_cyc_o = (state_q != FETCH_IDLE);
    assign imem_stb_o = (state_q != FETCH_IDLE);
    assign imem_adr_o = adr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= FETCH_IDLE;
            pc_q    <= RESET_PC;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    state_q <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (imem_ack_i) begin
                        state_q <= FETCH_IDLE;
                        pc_q    <= redirect_i ? redirect_pc_i : adr_q + 32'd4;
                    end else if (redirect_i) begin
                        // Cycle cannot be aborted, so its word is thrown away
                        state_q <= FETCH_DROP;
                        pc_q    <= redirect_pc_i;
                    end
                end
                default: begin
                    if (imem_ack_i) begin
                        state_q <= FETCH_IDLE;
                    end
                    if (redirect_i) begin
                        pc_q <= redirect_pc_i;
                    end
                end
            endcase
        end
    end

    // Address held stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (state_q == FETCH_IDLE) begin
            adr_q <= redirect_i ? redirect_pc_i : pc_q;
        end
    end

    // IF/ID register, a bubble between fetches or on a flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= fetch_done && !flush_id_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done && !flush_id_i) begin
            id_pc_o    <= adr_q;
            id_instr_o <= imem_dat_i;
        end else begin
            id_instr_o <= INSTR_NOP;
        end
    end

endmodule : fetch_unit

`default_nettype wire

// File: design/register_file.sv
/*
 Integer register file: two read ports with write-through bypass,
 one write port, x0 fixed at zero
*/
`default_nettype none

module register_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o,

    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  word_t    wd_i
);

    word_t regs_q [NUM_REGS];
    logic  write_hit;

    // Writes to x0 are dropped
    assign write_hit = we_i && (rd_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_hit) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    // Same-cycle write is visible to decode, covers distance two
    assign rs1_data_o = (write_hit && rd_i == rs1_i) ? wd_i : regs_q[rs1_i];
    assign rs2_data_o = (write_hit && rd_i == rs2_i) ? wd_i : regs_q[rs2_i];

endmodule : register_file

`default_nettype wire

// File: design/core_pkg.sv
/*
 Core package for the in-order integer pipeline: widths, opcodes,
 reset values and the encodings of the ALU and fetch state machine
*/
`default_nettype none

package core_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // ADDI x0, x0, 0
    localparam instr_t INSTR_NOP = 32'h0000_0013;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // DROP discards the word of a cycle overtaken by a redirect
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_DROP
    } fetch_state_e;

endpackage : core_pkg

`default_nettype wire
